/* color_tracker.f */
video_pkg.sv
color_pkg.sv
color_convert.sv
channel_threshold.sv
com_divider.sv
com_accumulator.sv
overlay_mux.sv
color_tracker.sv
color_tracker_sva.sv
tb_color_tracker.sv

/* run_sim.sh */
#!/bin/sh
# build and run the color tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_color_tracker -f color_tracker.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_color_tracker 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Result: PASSED$"; then
  exit 0
fi
exit 1

/* tb_color_tracker.sv */
module tb_color_tracker;
  import video_pkg::*;
  import color_pkg::*;

  localparam int H_ACTIVE        = 16;
  localparam int LINE_CYCLES     = 20;                         // 16 active + 4 hblank
  localparam int ACTIVE_LINES    = 8;
  localparam int V_START         = ACTIVE_LINES * LINE_CYCLES; // first vblank cycle
  localparam int FRAME_CYCLES    = V_START + 48;
  localparam int NUM_FRAMES      = 40;
  localparam int PIPE_DEPTH      = 5;                          // input to pixel_out latency
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES + 1000;

  logic          clk_pixel = 1'b0;
  logic          sys_rst;
  rgb565_t       pixel;
  video_timing_t timing;
  channel_sel_t  channel_sel;
  chan_t         lower_bound;
  chan_t         upper_bound;
  bg_sel_t       bg_sel;
  target_sel_t   target_sel;
  rgb888_t       pixel_out;
  video_timing_t timing_out;
  hcount_t       x_com;
  vcount_t       y_com;
  logic          com_valid;

  logic [31:0]   lcg_state = 32'h25ed;
  rgb888_t       pix_q [$];         // expected pixels, oldest first
  video_timing_t tim_q [$];
  hcount_t       cx = '0;           // model center, starts where the DUT resets
  vcount_t       cy = '0;
  int            xs = 0;            // model sums over masked pixels
  int            ys = 0;
  int            hits = 0;
  logic          com_pending = 1'b0; // a center is owed for the frame that ended

  always #10 clk_pixel = ~clk_pixel;

  color_tracker #(.SUM_BITS(32)) color_tracker_i (
    .clk_pixel (clk_pixel), .sys_rst (sys_rst), .pixel (pixel), .timing (timing),
    .channel_sel (channel_sel), .lower_bound (lower_bound), .upper_bound (upper_bound),
    .bg_sel (bg_sel), .target_sel (target_sel), .pixel_out (pixel_out),
    .timing_out (timing_out), .x_com (x_com), .y_com (y_com), .com_valid (com_valid)
  );

  bind color_tracker color_tracker_sva color_tracker_sva_i (
    .clk_pixel (clk_pixel), .sys_rst (sys_rst), .com_valid (com_valid),
    .x_com (x_com), .y_com (y_com), .timing_out (timing_out)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rgb888_t expand_565(rgb565_t p);
    rgb888_t c;
    c.red   = {p[15:11], 3'b000}; // fields shifted up, zeros below
    c.green = {p[10:5], 2'b00};
    c.blue  = {p[4:0], 3'b000};
    return c;
  endfunction

  function automatic ycrcb_t to_ycrcb(rgb888_t c);
    int     r;
    int     g;
    int     b;
    ycrcb_t res;
    r = int'(c.red);
    g = int'(c.green);
    b = int'(c.blue);
    res.y  = chan_t'((77 * r + 150 * g + 29 * b) >>> 8);
    res.cr = chan_t'(((128 * r - 107 * g - 21 * b) >>> 8) + 128); // signed before offset
    res.cb = chan_t'(((-43 * r - 85 * g + 128 * b) >>> 8) + 128);
    return res;
  endfunction

  function automatic chan_t pick_channel(channel_sel_t code, rgb888_t c, ycrcb_t ycc);
    case (code)
      3'b000:  return c.green;
      3'b001:  return c.red;
      3'b010:  return c.blue;
      3'b100:  return ycc.y;
      3'b101:  return ycc.cr;
      3'b110:  return ycc.cb;
      default: return 8'h00; // 011 and 111
    endcase
  endfunction

  // raster of 8 lines of 20 cycles, then 48 cycles of vblank
  function automatic video_timing_t make_timing(int c);
    video_timing_t t;
    t = '0;
    if (c < V_START) begin
      t.hcount      = hcount_t'(c % LINE_CYCLES);
      t.vcount      = vcount_t'(c / LINE_CYCLES);
      t.active_draw = (c % LINE_CYCLES) < H_ACTIVE;
      t.hsync       = (c % LINE_CYCLES) == H_ACTIVE + 1;
    end else begin
      t.hcount    = hcount_t'(c - V_START);
      t.vcount    = vcount_t'(ACTIVE_LINES);
      t.vsync     = (c >= V_START + 4) && (c < V_START + 8);
      t.new_frame = (c == V_START);
    end
    return t;
  endfunction

  task automatic stop_on_error();
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_rgb(rgb888_t got, rgb888_t want);
    if (got !== want) begin
      $display("[ERROR] pixel_out got %h expected %h", got, want);
      stop_on_error();
    end
  endtask

  task automatic check_timing(video_timing_t got, video_timing_t want);
    if (got !== want) begin
      $display("[ERROR] timing_out got %h expected %h", got, want);
      stop_on_error();
    end
  endtask

  task automatic check_com(hcount_t got_x, vcount_t got_y, hcount_t want_x, vcount_t want_y);
    if (got_x !== want_x) begin
      $display("[ERROR] x_com got %h expected %h", got_x, want_x);
      stop_on_error();
    end
    if (got_y !== want_y) begin
      $display("[ERROR] y_com got %h expected %h", got_y, want_y);
      stop_on_error();
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_pixel);
    $display("watchdog expired before the stimulus finished");
    stop_on_error();
  end

  initial begin
    logic [31:0]   rnd;
    rgb565_t       pix;
    video_timing_t tim;
    rgb888_t       rgb;
    ycrcb_t        ycc;
    chan_t         ch;
    logic          hit;
    rgb888_t       want;
    sys_rst     = 1'b1;
    pixel       = '0;
    timing      = '0;
    channel_sel = '0; // first frame runs camera background, no target
    lower_bound = '0;
    upper_bound = '0;
    bg_sel      = '0;
    target_sel  = '0;
    repeat (4) @(posedge clk_pixel);
    sys_rst <= 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int c = 0; c < FRAME_CYCLES; c++) begin
        @(posedge clk_pixel);
        rnd = next_rand();
        pix = rnd[31:16];
        tim = make_timing(c);
        pixel  <= pix;
        timing <= tim;
        if (c == V_START + 10) begin // new settings well inside vblank
          rnd = next_rand();
          channel_sel <= rnd[31:29];
          bg_sel      <= rnd[28:27];
          target_sel  <= rnd[26:25];
          lower_bound <= rnd[23:16];
          upper_bound <= rnd[23:16] + {1'b0, rnd[14:8]}; // wraps now and then, lower > upper
        end
        rgb = expand_565(pix);
        ycc = to_ycrcb(rgb);
        ch  = pick_channel(channel_sel, rgb, ycc);
        hit = tim.active_draw && (ch >= lower_bound) && (ch <= upper_bound);
        want = '0;
        if (tim.active_draw) begin
          case (bg_sel)
            2'b00: want = rgb;
            2'b01: want = '{ch, ch, ch};
            2'b10: if (hit) want = 24'hFFFFFF;
            default: begin
              if (hit) want = 24'hFF00FF;
              else want = '{ycc.y, ycc.y, ycc.y};
            end
          endcase
          if (target_sel == 2'b01 && (tim.hcount == cx || tim.vcount == cy)) want = 24'hFFFFFF;
          if (com_pending) begin
            $display("no com_valid arrived before the next frame started");
            stop_on_error();
          end
        end
        if (hit) begin
          xs += int'(tim.hcount);
          ys += int'(tim.vcount);
          hits++;
        end
        if (tim.new_frame) begin
          if (hits != 0) begin
            cx = hcount_t'(xs / hits); // truncating means
            cy = vcount_t'(ys / hits);
            com_pending = 1'b1;
          end
          xs   = 0;
          ys   = 0;
          hits = 0;
        end
        @(negedge clk_pixel); // outputs settled mid cycle
        if (pix_q.size() == PIPE_DEPTH) begin
          check_rgb(pixel_out, pix_q.pop_front());
          check_timing(timing_out, tim_q.pop_front());
        end
        pix_q.push_back(want);
        tim_q.push_back(tim);
        if (com_valid) begin
          if (!com_pending) begin
            $display("com_valid pulsed although the frame had no masked pixel");
            stop_on_error();
          end
          check_com(x_com, y_com, cx, cy);
          com_pending = 1'b0;
        end
      end
    end
    if (com_pending) begin
      $display("the center of mass of the last frame never arrived");
      stop_on_error();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* color_tracker_sva.sv */
module color_tracker_sva (
  input logic                     clk_pixel,
  input logic                     sys_rst,
  input logic                     com_valid,
  input video_pkg::hcount_t       x_com,
  input video_pkg::vcount_t       y_com,
  input video_pkg::video_timing_t timing_out
);

  // one strobe per finished frame
  com_valid_pulse: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    com_valid |=> !com_valid)
    else $error("com_valid stayed high for more than one cycle");

  // center only moves together with the strobe
  com_hold: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !com_valid |-> ($stable(x_com) && $stable(y_com)))
    else $error("x_com or y_com changed without com_valid");

  // first cycle out of reset still shows the cleared flags
  flags_after_reset: assert property (@(posedge clk_pixel)
    $fell(sys_rst) |-> ({timing_out.active_draw, timing_out.hsync,
                         timing_out.vsync, timing_out.new_frame} == 4'b0000))
    else $error("timing_out flags not cleared after reset");

endmodule

/* color_tracker.sv */
module color_tracker #(
  parameter int SUM_BITS = 32 // width of the position sums and the dividers
) (
  input  logic                     clk_pixel,
  input  logic                     sys_rst,
  input  color_pkg::rgb565_t       pixel,
  input  video_pkg::video_timing_t timing,
  input  color_pkg::channel_sel_t  channel_sel,
  input  color_pkg::chan_t         lower_bound,
  input  color_pkg::chan_t         upper_bound,
  input  color_pkg::bg_sel_t       bg_sel,
  input  color_pkg::target_sel_t   target_sel,
  output color_pkg::rgb888_t       pixel_out,
  output video_pkg::video_timing_t timing_out,
  output video_pkg::hcount_t       x_com,
  output video_pkg::vcount_t       y_com,
  output logic                     com_valid
);
  import color_pkg::*;

  conv_stage_t conv;  // 3 cycles after input
  mask_stage_t stage; // 4 cycles after input

  color_convert color_convert_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .pixel     (pixel),
    .timing    (timing),
    .conv      (conv)
  );

  channel_threshold channel_threshold_i (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .conv        (conv),
    .channel_sel (channel_sel),
    .lower_bound (lower_bound),
    .upper_bound (upper_bound),
    .stage       (stage)
  );

  com_accumulator #(.SUM_BITS(SUM_BITS)) com_accumulator_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .stage     (stage),
    .x_com     (x_com),
    .y_com     (y_com),
    .com_valid (com_valid)
  );

  // output register makes the 5th cycle
  overlay_mux overlay_mux_i (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .stage      (stage),
    .bg_sel     (bg_sel),
    .target_sel (target_sel),
    .x_com      (x_com),
    .y_com      (y_com),
    .pixel_out  (pixel_out),
    .timing_out (timing_out)
  );

endmodule

/* overlay_mux.sv */
module overlay_mux (
  input  logic                     clk_pixel,
  input  logic                     sys_rst,
  input  color_pkg::mask_stage_t   stage,
  input  color_pkg::bg_sel_t       bg_sel,
  input  color_pkg::target_sel_t   target_sel,
  input  video_pkg::hcount_t       x_com,
  input  video_pkg::vcount_t       y_com,
  output color_pkg::rgb888_t       pixel_out,
  output video_pkg::video_timing_t timing_out
);
  import color_pkg::*;

  rgb888_t bg_pix;   // background before the target goes on top
  rgb888_t pix_next;
  logic    on_cross; // pixel sits on the center row or column

  always_comb begin
    case (bg_sel)
      BG_CAMERA:  bg_pix = stage.rgb;
      BG_CHANNEL: bg_pix = '{stage.channel, stage.channel, stage.channel}; // gray
      BG_MASK: begin
        if (stage.mask) bg_pix = RGB_WHITE;
        else bg_pix = '0;
      end
      BG_MAGENTA: begin
        if (stage.mask) bg_pix = RGB_MAGENTA;
        else bg_pix = '{stage.y, stage.y, stage.y}; // luma as gray
      end
      default: bg_pix = '0;
    endcase
  end

  assign on_cross = (target_sel == TGT_CROSSHAIR) &&
                    ((stage.timing.hcount == x_com) || (stage.timing.vcount == y_com));

  always_comb begin
    if (!stage.timing.active_draw) pix_next = '0; // black in blanking
    else if (on_cross) pix_next = RGB_WHITE;
    else pix_next = bg_pix;
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) timing_out <= '0;
    else timing_out <= stage.timing;
  end

  always_ff @(posedge clk_pixel) begin
    pixel_out <= pix_next;
  end

endmodule

/* com_accumulator.sv */
module com_accumulator #(
  parameter int SUM_BITS = 32
) (
  input  logic                   clk_pixel,
  input  logic                   sys_rst,
  input  color_pkg::mask_stage_t stage,
  output video_pkg::hcount_t     x_com,
  output video_pkg::vcount_t     y_com,
  output logic                   com_valid
);
  import video_pkg::*;

  logic [SUM_BITS-1:0] x_sum;     // running sum of hcount over hits
  logic [SUM_BITS-1:0] y_sum;
  logic [SUM_BITS-1:0] pix_count; // number of masked pixels this frame
  logic                div_start;
  logic [SUM_BITS-1:0] x_quo;
  logic [SUM_BITS-1:0] y_quo;
  logic                x_done;
  logic                y_done;

  // dividers take the totals straight from the sum registers
  assign div_start = stage.timing.new_frame && (pix_count != '0);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst || stage.timing.new_frame) begin
      x_sum     <= '0;
      y_sum     <= '0;
      pix_count <= '0;
    end else if (stage.mask) begin
      x_sum     <= x_sum + SUM_BITS'(stage.timing.hcount);
      y_sum     <= y_sum + SUM_BITS'(stage.timing.vcount);
      pix_count <= pix_count + 1'b1;
    end
  end

  com_divider #(.SUM_BITS(SUM_BITS)) x_div_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (x_sum),
    .divisor   (pix_count),
    .quotient  (x_quo),
    .done      (x_done)
  );

  com_divider #(.SUM_BITS(SUM_BITS)) y_div_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (y_sum),
    .divisor   (pix_count),
    .quotient  (y_quo),
    .done      (y_done)
  );

  // both dividers run in lockstep; center and valid move together
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      x_com     <= '0;
      y_com     <= '0;
      com_valid <= 1'b0;
    end else begin
      com_valid <= x_done && y_done;
      if (x_done && y_done) begin
        x_com <= hcount_t'(x_quo); // mean never exceeds the largest hcount
        y_com <= vcount_t'(y_quo);
      end
    end
  end

endmodule

/* com_divider.sv */
module com_divider #(
  parameter int SUM_BITS = 32
) (
  input  logic                clk_pixel,
  input  logic                sys_rst,
  input  logic                start,
  input  logic [SUM_BITS-1:0] dividend,
  input  logic [SUM_BITS-1:0] divisor,
  output logic [SUM_BITS-1:0] quotient,
  output logic                done
);
  localparam int CNT_BITS = $clog2(SUM_BITS);

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_FINISH} div_state_t;

  div_state_t          state;
  logic [CNT_BITS-1:0] bit_cnt;  // quotient bits still to produce, minus one
  logic [SUM_BITS-1:0] quo_q;    // dividend shifts out the top, quotient in at the bottom
  logic [SUM_BITS-1:0] rem_q;    // partial remainder
  logic [SUM_BITS-1:0] div_q;
  logic [SUM_BITS:0]   shifted;  // remainder with next dividend bit appended
  logic [SUM_BITS:0]   trial;

  assign shifted = {rem_q, quo_q[SUM_BITS-1]};
  assign trial   = shifted - {1'b0, div_q}; // msb set means divisor did not fit

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state <= DIV_IDLE;
    end else begin
      case (state)
        DIV_IDLE:   if (start) state <= DIV_RUN;
        DIV_RUN:    if (bit_cnt == '0) state <= DIV_FINISH; // last bit lands this edge
        DIV_FINISH: state <= DIV_IDLE;
        default:    state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (state == DIV_IDLE && start) begin
      quo_q   <= dividend;
      div_q   <= divisor;
      rem_q   <= '0;
      bit_cnt <= CNT_BITS'(SUM_BITS - 1);
    end else if (state == DIV_RUN) begin
      bit_cnt <= bit_cnt - 1'b1;
      if (!trial[SUM_BITS]) begin
        rem_q <= trial[SUM_BITS-1:0];
        quo_q <= {quo_q[SUM_BITS-2:0], 1'b1};
      end else begin
        rem_q <= shifted[SUM_BITS-1:0]; // restore
        quo_q <= {quo_q[SUM_BITS-2:0], 1'b0};
      end
    end
  end

  assign quotient = quo_q;
  assign done     = (state == DIV_FINISH); // one cycle, SUM_BITS+1 after start

endmodule

/* channel_threshold.sv */
module channel_threshold (
  input  logic                    clk_pixel,
  input  logic                    sys_rst,
  input  color_pkg::conv_stage_t  conv,
  input  color_pkg::channel_sel_t channel_sel,
  input  color_pkg::chan_t        lower_bound,
  input  color_pkg::chan_t        upper_bound,
  output color_pkg::mask_stage_t  stage
);
  import video_pkg::*;
  import color_pkg::*;

  chan_t         chan_pick; // channel chosen by code, not yet registered
  logic          in_range;
  video_timing_t timing_q;
  logic          mask_q;
  rgb888_t       rgb_q;
  chan_t         y_q;
  chan_t         chan_q;

  always_comb begin
    case (channel_sel)
      CH_GREEN: chan_pick = conv.rgb.green;
      CH_RED:   chan_pick = conv.rgb.red;
      CH_BLUE:  chan_pick = conv.rgb.blue;
      CH_Y:     chan_pick = conv.ycc.y;
      CH_CR:    chan_pick = conv.ycc.cr;
      CH_CB:    chan_pick = conv.ycc.cb;
      default:  chan_pick = '0; // 011 and 111 are unused codes
    endcase
  end

  // inclusive at both ends; lower above upper never passes
  assign in_range = conv.timing.active_draw &&
                    (chan_pick >= lower_bound) && (chan_pick <= upper_bound);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      timing_q <= '0;
      mask_q   <= 1'b0;
    end else begin
      timing_q <= conv.timing;
      mask_q   <= in_range;
    end
  end

  always_ff @(posedge clk_pixel) begin
    rgb_q  <= conv.rgb;
    y_q    <= conv.ycc.y; // luma for the magenta background
    chan_q <= chan_pick;
  end

  assign stage = '{timing: timing_q, rgb: rgb_q, y: y_q, channel: chan_q, mask: mask_q};

endmodule

/* color_convert.sv */
module color_convert (
  input  logic                     clk_pixel,
  input  logic                     sys_rst,
  input  color_pkg::rgb565_t       pixel,
  input  video_pkg::video_timing_t timing,
  output color_pkg::conv_stage_t   conv
);
  import video_pkg::*;
  import color_pkg::*;

  typedef logic signed [17:0] term_t; // holds 150*255 and the signed sums

  rgb888_t       rgb_exp;      // pixel expanded to 8 bits per channel
  term_t         r_t;
  term_t         g_t;
  term_t         b_t;
  term_t         prod [9];     // rows of three for y, cr, cb
  term_t         sum [3];      // y, cr, cb before the shift
  ycrcb_t        ycc_q;
  rgb888_t       rgb_q [3];    // rgb beside each step
  video_timing_t timing_q [3]; // timing beside each step

  // low bits zero filled
  assign rgb_exp.red   = {pixel[15:11], 3'b000};
  assign rgb_exp.green = {pixel[10:5], 2'b00};
  assign rgb_exp.blue  = {pixel[4:0], 3'b000};

  // zero extended, always positive
  assign r_t = term_t'(rgb_exp.red);
  assign g_t = term_t'(rgb_exp.green);
  assign b_t = term_t'(rgb_exp.blue);

  always_ff @(posedge clk_pixel) begin
    // step 1, weighted products
    prod[0] <= 18'sd77 * r_t;
    prod[1] <= 18'sd150 * g_t;
    prod[2] <= 18'sd29 * b_t;
    prod[3] <= 18'sd128 * r_t;
    prod[4] <= -18'sd107 * g_t;
    prod[5] <= -18'sd21 * b_t;
    prod[6] <= -18'sd43 * r_t;
    prod[7] <= -18'sd85 * g_t;
    prod[8] <= 18'sd128 * b_t;
    // step 2, row sums
    sum[0] <= prod[0] + prod[1] + prod[2];
    sum[1] <= prod[3] + prod[4] + prod[5];
    sum[2] <= prod[6] + prod[7] + prod[8];
    // step 3, arithmetic shift, chroma offset, keep 8 bits
    ycc_q.y  <= chan_t'(sum[0] >>> 8);
    ycc_q.cr <= chan_t'((sum[1] >>> 8) + 18'sd128);
    ycc_q.cb <= chan_t'((sum[2] >>> 8) + 18'sd128);
    rgb_q[0] <= rgb_exp;
    rgb_q[1] <= rgb_q[0];
    rgb_q[2] <= rgb_q[1];
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      timing_q <= '{default: '0}; // flags low while in reset
    end else begin
      timing_q[0] <= timing;
      timing_q[1] <= timing_q[0];
      timing_q[2] <= timing_q[1];
    end
  end

  assign conv = '{timing: timing_q[2], rgb: rgb_q[2], ycc: ycc_q};

endmodule

/* color_pkg.sv */
package color_pkg;

  typedef logic [15:0] rgb565_t;   // raw camera pixel, r5 g6 b5
  typedef logic [7:0]  chan_t;     // any single 8-bit channel
  typedef logic [2:0]  channel_sel_t;
  typedef logic [1:0]  bg_sel_t;
  typedef logic [1:0]  target_sel_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb888_t;

  typedef struct packed {
    chan_t y;
    chan_t cr;
    chan_t cb;
  } ycrcb_t;

  // converter output, rgb and ycrcb of the same pixel
  typedef struct packed {
    video_pkg::video_timing_t timing;
    rgb888_t                  rgb;
    ycrcb_t                   ycc;
  } conv_stage_t;

  // threshold output
  typedef struct packed {
    video_pkg::video_timing_t timing;
    rgb888_t                  rgb;
    chan_t                    y;       // luma kept for the gray background
    chan_t                    channel; // channel picked by channel_sel
    logic                     mask;
  } mask_stage_t;

  localparam channel_sel_t CH_GREEN = 3'b000;
  localparam channel_sel_t CH_RED   = 3'b001;
  localparam channel_sel_t CH_BLUE  = 3'b010;
  localparam channel_sel_t CH_Y     = 3'b100;
  localparam channel_sel_t CH_CR    = 3'b101;
  localparam channel_sel_t CH_CB    = 3'b110;

  localparam bg_sel_t BG_CAMERA  = 2'b00;
  localparam bg_sel_t BG_CHANNEL = 2'b01;
  localparam bg_sel_t BG_MASK    = 2'b10;
  localparam bg_sel_t BG_MAGENTA = 2'b11;

  localparam target_sel_t TGT_CROSSHAIR = 2'b01; // other codes draw nothing

  localparam rgb888_t RGB_WHITE   = 24'hFFFFFF;
  localparam rgb888_t RGB_MAGENTA = 24'hFF00FF;

endpackage

/* video_pkg.sv */
package video_pkg;

  localparam int HCOUNT_BITS = 11; // up to 2047 columns
  localparam int VCOUNT_BITS = 10; // up to 1023 lines

  typedef logic [HCOUNT_BITS-1:0] hcount_t; // horizontal pixel position
  typedef logic [VCOUNT_BITS-1:0] vcount_t; // vertical pixel position

  // raster position and flags that ride along with every pixel
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    logic    active_draw; // pixel lies inside the visible area
    logic    hsync;
    logic    vsync;
    logic    new_frame;   // single-cycle pulse in vertical blank
  } video_timing_t;

endpackage
